// File: design/stream_pkg.sv
package stream_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // widths and sizes
    ////////////////////////////////////////////////////////////////////////////

    localparam int INST_WIDTH    = 16;
    localparam int DATA_WIDTH    = 16;
    localparam int IM_ADDR_WIDTH = 4;
    localparam int IM_DEPTH      = 2 ** IM_ADDR_WIDTH;
    localparam int OP_WIDTH      = 4;
    localparam int REG_IDX_WIDTH = 3;
    localparam int REG_COUNT     = 8;

    // first sampled word to first replay read, also the max burst length
    localparam int LOAD_DELAY = 9;

    typedef logic [INST_WIDTH-1:0]    inst_t;
    typedef logic [IM_ADDR_WIDTH-1:0] im_addr_t;
    typedef logic [OP_WIDTH-1:0]      opcode_t;
    typedef logic [REG_IDX_WIDTH-1:0] reg_idx_t;
    typedef logic [DATA_WIDTH-1:0]    data_t;

    ////////////////////////////////////////////////////////////////////////////
    // opcodes, bits 15..12 of the word
    ////////////////////////////////////////////////////////////////////////////

    localparam opcode_t OP_NOP = 4'd0;
    // rd = zext(imm8)
    localparam opcode_t OP_LDI = 4'd1;
    localparam opcode_t OP_ADD = 4'd2;
    localparam opcode_t OP_SUB = 4'd3;
    localparam opcode_t OP_XOR = 4'd4;
    // put rd on the result port
    localparam opcode_t OP_OUT = 4'd5;

endpackage

// File: design/inst_mem.sv
`timescale 1ns/1ps

module inst_mem import stream_pkg::*; (
    input  logic  clk,
    input  logic  ctrl,
    input  logic  inst_v,
    input  inst_t inst_in,
    output logic  shift_v,
    output inst_t inst_out,
    output logic  inst_out_v
);

    inst_t           mem [IM_DEPTH];
    logic            wr_en;
    logic            wr_en_r;
    inst_t           inst_in_r;
    im_addr_t        wr_addr_r;
    im_addr_t        load_cnt;
    logic [LOAD_DELAY-1:0] dly;
    logic            replay;
    logic            replay_end;
    im_addr_t        rd_cnt;
    im_addr_t        rd_addr_r;
    logic            rd_valid_r;

    // host words only count while the engine is loading
    assign wr_en = inst_v & shift_v;

    // last read of the burst, load count still holds N here
    assign replay_end = replay & (rd_cnt == im_addr_t'(load_cnt - 1'b1));

    ////////////////////////////////////////////////////////////////////////////
    // load side
    ////////////////////////////////////////////////////////////////////////////

    // registered write path
    always_ff @(posedge clk) begin
        inst_in_r <= inst_in;
        wr_addr_r <= load_cnt;
        if (wr_en_r) begin
            mem[wr_addr_r] <= inst_in_r;
        end
    end

    always_ff @(posedge clk or negedge ctrl) begin
        if (!ctrl) begin
            wr_en_r  <= 1'b0;
            load_cnt <= '0;
            dly      <= '0;
        end else begin
            wr_en_r <= wr_en;
            // next program starts at address 0 again
            if (replay_end) begin
                load_cnt <= '0;
            end else if (wr_en) begin
                load_cnt <= load_cnt + 1'b1;
            end
            // accepted valids only, so ignored words never launch a replay
            dly <= {dly[LOAD_DELAY-2:0], wr_en};
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // replay side
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge ctrl) begin
        if (!ctrl) begin
            replay     <= 1'b0;
            rd_cnt     <= '0;
            rd_valid_r <= 1'b0;
            inst_out_v <= 1'b0;
        end else begin
            // delay line tap opens the window
            if (dly[LOAD_DELAY-1] && !replay) begin
                replay <= 1'b1;
            end else if (replay_end) begin
                replay <= 1'b0;
            end
            if (replay_end) begin
                rd_cnt <= '0;
            end else if (replay) begin
                rd_cnt <= rd_cnt + 1'b1;
            end
            rd_valid_r <= replay;
            inst_out_v <= rd_valid_r;
        end
    end

    // address stage then read stage
    always_ff @(posedge clk) begin
        rd_addr_r <= rd_cnt;
        inst_out  <= mem[rd_addr_r];
    end

    // drops as soon as replay goes high, back on the edge after it ends
    always_ff @(posedge clk or negedge ctrl or posedge replay) begin
        if (!ctrl) begin
            shift_v <= 1'b1;
        end else if (replay) begin
            shift_v <= 1'b0;
        end else begin
            shift_v <= 1'b1;
        end
    end

endmodule

// File: design/inst_decode.sv
`timescale 1ns/1ps

module inst_decode import stream_pkg::*; (
    input  logic     clk,
    input  logic     ctrl,
    input  inst_t    inst_out,
    input  logic     inst_out_v,
    output logic     dec_v,
    output opcode_t  dec_op,
    output reg_idx_t dec_rd,
    output reg_idx_t dec_rs,
    output data_t    dec_imm
);

    opcode_t raw_op;
    opcode_t legal_op;

    ////////////////////////////////////////////////////////////////////////////
    // field split
    ////////////////////////////////////////////////////////////////////////////

    // opcode in the top nibble
    assign raw_op = inst_out[15:12];

    // anything past OUT is undefined, squash to nop
    assign legal_op = (raw_op > OP_OUT) ? OP_NOP : raw_op;

    always_ff @(posedge clk or negedge ctrl) begin
        if (!ctrl) begin
            dec_v <= 1'b0;
        end else begin
            dec_v <= inst_out_v;
        end
    end

    // fields only move on a valid word
    always_ff @(posedge clk) begin
        if (inst_out_v) begin
            dec_op  <= legal_op;
            // destination 10..8, source 2..0
            dec_rd  <= inst_out[10:8];
            dec_rs  <= inst_out[2:0];
            // imm8 zero extended to data width
            dec_imm <= data_t'(inst_out[7:0]);
        end
    end

endmodule

// File: design/exec_unit.sv
`timescale 1ns/1ps

module exec_unit import stream_pkg::*; (
    input  logic     clk,
    input  logic     ctrl,
    input  logic     dec_v,
    input  opcode_t  dec_op,
    input  reg_idx_t dec_rd,
    input  reg_idx_t dec_rs,
    input  data_t    dec_imm,
    output logic     result_v,
    output data_t    result
);

    data_t regs [REG_COUNT];
    data_t rd_val;
    data_t rs_val;
    data_t alu_res;
    logic  alu_we;
    logic  is_out;

    ////////////////////////////////////////////////////////////////////////////
    // operand read and alu
    ////////////////////////////////////////////////////////////////////////////

    // previous write has already landed, no bypass needed
    assign rd_val = regs[dec_rd];
    assign rs_val = regs[dec_rs];
    assign is_out = dec_v && (dec_op == OP_OUT);

    always_comb begin
        alu_res = rd_val;
        alu_we  = 1'b0;
        case (dec_op)
            OP_LDI: begin
                alu_res = dec_imm;
                alu_we  = 1'b1;
            end
            // wraps mod 2^16
            OP_ADD: begin
                alu_res = rd_val + rs_val;
                alu_we  = 1'b1;
            end
            OP_SUB: begin
                alu_res = rd_val - rs_val;
                alu_we  = 1'b1;
            end
            OP_XOR: begin
                alu_res = rd_val ^ rs_val;
                alu_we  = 1'b1;
            end
            // nop, out and anything else leave the bank alone
            default: begin
                alu_res = rd_val;
                alu_we  = 1'b0;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // register bank and result port
    ////////////////////////////////////////////////////////////////////////////

    // bank survives across programs, only reset clears it
    always_ff @(posedge clk or negedge ctrl) begin
        if (!ctrl) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
            result_v <= 1'b0;
        end else begin
            if (dec_v && alu_we) begin
                regs[dec_rd] <= alu_res;
            end
            // one pulse per out
            result_v <= is_out;
        end
    end

    always_ff @(posedge clk) begin
        if (is_out) begin
            result <= rd_val;
        end
    end

endmodule

// File: design/stream_top.sv
`timescale 1ns/1ps

module stream_top import stream_pkg::*; (
    input  logic  clk,
    input  logic  ctrl,
    input  logic  inst_v,
    input  inst_t inst_in,
    output logic  shift_v,
    output logic  result_v,
    output data_t result
);

    // memory to decoder
    inst_t    inst_out;
    logic     inst_out_v;

    // decoder to executor
    logic     dec_v;
    opcode_t  dec_op;
    reg_idx_t dec_rd;
    reg_idx_t dec_rs;
    data_t    dec_imm;

    ////////////////////////////////////////////////////////////////////////////
    // load and replay, then decode, then execute
    ////////////////////////////////////////////////////////////////////////////

    inst_mem u_inst_mem (
        .clk        (clk),
        .ctrl       (ctrl),
        .inst_v     (inst_v),
        .inst_in    (inst_in),
        .shift_v    (shift_v),
        .inst_out   (inst_out),
        .inst_out_v (inst_out_v)
    );

    inst_decode u_inst_decode (
        .clk        (clk),
        .ctrl       (ctrl),
        .inst_out   (inst_out),
        .inst_out_v (inst_out_v),
        .dec_v      (dec_v),
        .dec_op     (dec_op),
        .dec_rd     (dec_rd),
        .dec_rs     (dec_rs),
        .dec_imm    (dec_imm)
    );

    exec_unit u_exec_unit (
        .clk      (clk),
        .ctrl     (ctrl),
        .dec_v    (dec_v),
        .dec_op   (dec_op),
        .dec_rd   (dec_rd),
        .dec_rs   (dec_rs),
        .dec_imm  (dec_imm),
        .result_v (result_v),
        .result   (result)
    );

endmodule

// File: testbench/stream_checker.sv
`timescale 1ns/1ps

module stream_checker import stream_pkg::*; (
    input logic  clk,
    input logic  ctrl,
    input logic  inst_v,
    input logic  shift_v,
    input logic  result_v,
    input data_t result
);

    int    mismatch_count = 0;
    int    protocol_count = 0;
    data_t exp_q [$];
    data_t exp_val;
    logic  exp_shift;

    // burst and replay window model, edges counted from reset release
    int    cyc = 0;
    int    burst_n = 0;
    int    t0 = 0;
    int    rep_first = 0;
    int    rep_last = 0;
    logic  rep_active = 1'b0;

    ////////////////////////////////////////////////////////////////////////////
    // expected result queue
    ////////////////////////////////////////////////////////////////////////////

    task automatic push_expected(input data_t value);
        exp_q.push_back(value);
    endtask

    task automatic check_drained();
        if (exp_q.size() != 0) begin
            protocol_count = protocol_count + exp_q.size();
            $display("%0d expected results were never produced by the DUT", exp_q.size());
        end
    endtask

    // low from the replay start edge through the edge after the last read
    function automatic logic shift_expected();
        return !(rep_active && cyc >= rep_first && cyc <= rep_last);
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // burst tracking
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk or negedge ctrl) begin
        if (!ctrl) begin
            cyc        = 0;
            burst_n    = 0;
            t0         = 0;
            rep_first  = 0;
            rep_last   = 0;
            rep_active = 1'b0;
        end else begin
            // word only lands if the engine was loading before this edge
            if (inst_v && shift_expected()) begin
                if (burst_n == 0) begin
                    t0 = cyc + 1;
                end
                burst_n = burst_n + 1;
            end
            cyc = cyc + 1;
            // delay line tap, window is one cycle per loaded word
            if (burst_n > 0 && cyc == t0 + LOAD_DELAY) begin
                rep_first  = cyc;
                rep_last   = cyc + burst_n;
                rep_active = 1'b1;
                burst_n    = 0;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // compare on the falling edge, all dut outputs settled
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        exp_shift = shift_expected();
        if (shift_v !== exp_shift) begin
            protocol_count = protocol_count + 1;
            $display("Fail %0t: shift_v is %b, expected %b", $time, shift_v, exp_shift);
        end
        if (ctrl === 1'b1 && result_v === 1'b1) begin
            if (exp_q.size() == 0) begin
                protocol_count = protocol_count + 1;
                $display("result pulse at %0t with value %h but nothing was expected",
                         $time, result);
            end else begin
                exp_val = exp_q.pop_front();
                if (result !== exp_val) begin
                    mismatch_count = mismatch_count + 1;
                    $display("Fail %0t: result expected %h, got %h", $time, exp_val, result);
                end
            end
        end
    end

endmodule

// File: testbench/stream_tb.sv
`timescale 1ns/1ps

module stream_tb import stream_pkg::*; ();

    logic       clk = 1'b0;
    logic       ctrl;
    logic       inst_v;
    inst_t      inst_in;
    logic       shift_v;
    logic       result_v;
    data_t      result;

    // parsed records, kind letter and its value
    logic [7:0] kinds [$];
    int         vals [$];
    int         timeout_limit = 20;
    logic       limit_ready = 1'b0;
    int         cycle_count = 0;
    int         file_errors = 0;
    logic       file_ok;
    int         total_errors;

    // 100 ns period
    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    stream_top uut (
        .clk      (clk),
        .ctrl     (ctrl),
        .inst_v   (inst_v),
        .inst_in  (inst_in),
        .shift_v  (shift_v),
        .result_v (result_v),
        .result   (result)
    );

    stream_checker chk (
        .clk      (clk),
        .ctrl     (ctrl),
        .inst_v   (inst_v),
        .shift_v  (shift_v),
        .result_v (result_v),
        .result   (result)
    );

    ////////////////////////////////////////////////////////////////////////////
    // stimulus file
    ////////////////////////////////////////////////////////////////////////////

    task automatic read_stimulus(output logic ok);
        int         fd;
        int         code;
        int         c;
        logic [7:0] kind;
        int         value;
        fd = $fopen("testbench/stream_stimulus.txt", "r");
        ok = (fd != 0);
        if (ok) begin
            while ($fscanf(fd, " %c", kind) == 1) begin
                value = 0;
                code  = 1;
                case (kind)
                    // comment runs to end of line
                    "#": begin
                        c = $fgetc(fd);
                        while (c != 10 && c != -1) begin
                            c = $fgetc(fd);
                        end
                    end
                    "I", "E": code = $fscanf(fd, "%h", value);
                    "G": code = $fscanf(fd, "%d", value);
                    "W": code = 1;
                    default: code = 0;
                endcase
                if (code != 1) begin
                    file_errors = file_errors + 1;
                    $display("bad record of kind %c in the stimulus file", kind);
                end else if (kind != "#") begin
                    kinds.push_back(kind);
                    vals.push_back(value);
                    // one cycle per word, n per gap, worst replay per wait
                    if (kind == "I") timeout_limit = timeout_limit + 1;
                    if (kind == "G") timeout_limit = timeout_limit + value;
                    if (kind == "W") timeout_limit = timeout_limit + LOAD_DELAY + 16;
                end
            end
            $fclose(fd);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // drive, 5 ns after each rising edge
    ////////////////////////////////////////////////////////////////////////////

    task automatic apply_reset();
        ctrl = 1'b0;
        repeat (2) @(posedge clk);
        #5;
        ctrl = 1'b1;
    endtask

    task automatic run_records();
        for (int i = 0; i < kinds.size(); i++) begin
            case (kinds[i])
                "I": begin
                    inst_v  = 1'b1;
                    inst_in = inst_t'(vals[i]);
                    @(posedge clk);
                    #5;
                end
                "G": begin
                    inst_v = 1'b0;
                    repeat (vals[i]) begin
                        @(posedge clk);
                        #5;
                    end
                end
                "E": chk.push_expected(data_t'(vals[i]));
                // engine back in load mode
                "W": begin
                    inst_v = 1'b0;
                    while (shift_v !== 1'b1) begin
                        @(posedge clk);
                        #5;
                    end
                end
                default: ;
            endcase
        end
        inst_v = 1'b0;
    endtask

    initial begin
        ctrl    = 1'b0;
        inst_v  = 1'b0;
        inst_in = '0;
        read_stimulus(file_ok);
        if (!file_ok) begin
            $display("could not open the stimulus file");
            $display("Simulation failed");
        end else begin
            limit_ready = 1'b1;
            apply_reset();
            run_records();
            chk.check_drained();
            total_errors = chk.mismatch_count + chk.protocol_count + file_errors;
            $display("mismatches %0d, protocol errors %0d, stimulus file errors %0d",
                     chk.mismatch_count, chk.protocol_count, file_errors);
            if (total_errors == 0) begin
                $display("Simulation completed successfully");
            end else begin
                $display("Simulation failed");
            end
        end
        $finish;
    end

    // watchdog
    initial begin
        wait (limit_ready === 1'b1);
        wait (cycle_count >= timeout_limit);
        $display("run timed out after %0d cycles", cycle_count);
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: compile.f
design/stream_pkg.sv
design/inst_mem.sv
design/inst_decode.sv
design/exec_unit.sv
design/stream_top.sv
testbench/stream_checker.sv
testbench/stream_tb.sv

// File: testbench/stream_stimulus.txt
# I hex drives a word with inst_v high, G n idles n cycles
# E hex queues an expected OUT result, W waits for shift_v high
G 5
I 1100
I 12FF
I 135A
I 5100
I 5200
I 5300
E 0000
E 00FF
E 005A
G 9
W
I 1480
I 2402
I 2404
I 3504
I 4503
I 5400
I 5500
I 3302
I 5300
E 02FE
E FD58
E FF5B
G 9
W
I 5400
E 02FE
G 9
W
I 1601
I 6655
I D600
I 2503
I 5600
I 5500
E 0001
E FCB3
G 9
W
I 4605
I 5600
I 1733
I 5700
E FCB2
E 0033
G 7
I 5100
I 1744
W
I 5700
I 2706
I 5700
E 0033
E FCE5
G 9
W
G 6
